// ==== verilog/fir_defines.svh ====
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// sample, coefficient and bus width
`define FIR_DATA_W 16
`define FIR_TAPS 4
// 34 bits covers four full 32-bit products
`define FIR_ACC_W 34
`define FIR_ADDR_W 4

// halfword base byte addresses
`define FIR_ADDR_STATUS 4'd0
`define FIR_ADDR_RESULT 4'd2
`define FIR_ADDR_SAMPLE 4'd4
// coefficient k at 6 + 2k
`define FIR_ADDR_COEF0 4'd6
`define FIR_ADDR_RELOAD 4'd14

// status word bits
`define FIR_STATUS_BUSY_BIT 0
`define FIR_STATUS_ERR_BIT 8

`endif

// ==== verilog/fir_pkg.sv ====
`include "fir_defines.svh"

package fir_pkg;

    // hsize pin, only byte and halfword exist on a 16-bit bus
    typedef enum logic {
        HSIZE_BYTE = 1'b0,
        HSIZE_HALF = 1'b1
    } hsize_e;

    // address phase kept for the data phase
    typedef struct packed {
        logic                   sel;
        logic [`FIR_ADDR_W-1:0] addr;
        hsize_e                 size;
        // htrans non-idle
        logic                   active;
        logic                   write;
    } ahb_req_t;

    // entry k multiplies delay tap k
    typedef logic [`FIR_TAPS-1:0][`FIR_DATA_W-1:0] coeff_bank_t;

    typedef struct packed {
        logic [`FIR_DATA_W-1:0] value;
        logic                   err;
    } fir_result_t;

    typedef enum logic [1:0] {
        FIR_IDLE,
        FIR_SHIFT,
        FIR_MAC
    } fir_state_e;

    typedef enum logic {
        LD_IDLE,
        LD_RUN
    } load_state_e;

endpackage

// ==== verilog/ahb_lite_slave.sv ====
`timescale 1ns/100ps
`include "fir_defines.svh"

module ahb_lite_slave (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     hsel,
    input  logic [`FIR_ADDR_W-1:0]   haddr,
    input  fir_pkg::hsize_e          hsize,
    input  logic [1:0]               htrans,
    input  logic                     hwrite,
    input  logic [`FIR_DATA_W-1:0]   hwdata,
    output logic [`FIR_DATA_W-1:0]   hrdata,
    output logic                     hresp,
    output logic [`FIR_DATA_W-1:0]   sample_data,
    output logic                     data_ready,
    output logic                     new_coefficient_set,
    output logic [`FIR_DATA_W-1:0]   fir_coefficient,
    input  logic [1:0]               coefficient_num,
    input  logic                     coeff_done,
    input  logic                     modwait,
    input  fir_pkg::fir_result_t     result
);
    import fir_pkg::*;

    // byte table with one entry per bus address
    logic [(1 << `FIR_ADDR_W)-1:0][7:0] regs;
    ahb_req_t req_d;
    ahb_req_t req_q;
    logic addr_active;
    logic wr_ok;
    logic rd_ok;
    logic [`FIR_ADDR_W-1:0] lo_addr;
    logic [`FIR_ADDR_W-1:0] hi_addr;
    logic [`FIR_ADDR_W-1:0] coef_lo;
    logic [`FIR_DATA_W-1:0] status_word;
    logic [`FIR_DATA_W-1:0] rd_word;
    logic sample_wr;
    logic sample_wr_q;
    logic reload_wr;
    logic modwait_q;
    logic modwait_rise;

    // address phase checks see htrans only as idle or not
    assign addr_active = hsel && (htrans != 2'b00);
    // status and result are read only and byte 15 alone is not addressable
    assign hresp = addr_active &&
                   ((hwrite && (haddr < `FIR_ADDR_SAMPLE)) ||
                    ((hsize == HSIZE_BYTE) && (haddr == `FIR_ADDR_RELOAD + 4'd1)));

    always_comb begin
        req_d.sel    = hsel;
        req_d.addr   = haddr;
        req_d.size   = hsize;
        req_d.active = htrans != 2'b00;
        req_d.write  = hwrite;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            req_q <= '0;
        end else begin
            // errored access never reaches the data phase
            req_q <= hresp ? '0 : req_d;
        end
    end

    // data phase decode
    assign wr_ok = req_q.sel && req_q.active && req_q.write;
    assign rd_ok = req_q.sel && req_q.active && !req_q.write;
    // aligned halfword pair
    assign lo_addr = {req_q.addr[`FIR_ADDR_W-1:1], 1'b0};
    assign hi_addr = {req_q.addr[`FIR_ADDR_W-1:1], 1'b1};

    assign sample_wr = wr_ok && (req_q.size == HSIZE_HALF) && (lo_addr == `FIR_ADDR_SAMPLE);
    // byte 14 or halfword at 14 carries bit 0 on the low lane
    assign reload_wr = wr_ok && (lo_addr == `FIR_ADDR_RELOAD) && hwdata[0];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            regs <= '0;
        end else if (wr_ok) begin
            if (req_q.size == HSIZE_HALF) begin
                regs[lo_addr] <= hwdata[7:0];
                regs[hi_addr] <= hwdata[15:8];
            end else if (req_q.addr[0]) begin
                // odd byte rides the upper lane
                regs[hi_addr] <= hwdata[15:8];
            end else begin
                regs[lo_addr] <= hwdata[7:0];
            end
        end
    end

    // strobes toward loader and datapath
    assign modwait_rise = modwait && !modwait_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            modwait_q           <= 1'b0;
            sample_wr_q         <= 1'b0;
            data_ready          <= 1'b0;
            new_coefficient_set <= 1'b0;
        end else begin
            modwait_q   <= modwait;
            sample_wr_q <= sample_wr;
            // new sample wins; one landing on the start edge is still pending
            if (sample_wr) begin
                data_ready <= 1'b1;
            end else if (modwait_rise && !sample_wr_q) begin
                data_ready <= 1'b0;
            end
            if (reload_wr) begin
                new_coefficient_set <= 1'b1;
            end else if (coeff_done) begin
                new_coefficient_set <= 1'b0;
            end
        end
    end

    assign sample_data = {regs[`FIR_ADDR_SAMPLE + 4'd1], regs[`FIR_ADDR_SAMPLE]};

    // coefficient lookup for the loader
    assign coef_lo = `FIR_ADDR_COEF0 + {1'b0, coefficient_num, 1'b0};
    assign fir_coefficient = {regs[coef_lo + 4'd1], regs[coef_lo]};

    always_comb begin
        status_word = '0;
        status_word[`FIR_STATUS_BUSY_BIT] = new_coefficient_set || modwait;
        status_word[`FIR_STATUS_ERR_BIT]  = result.err;
    end

    // read mux followed by lane placement
    always_comb begin
        case (lo_addr)
            `FIR_ADDR_STATUS: rd_word = status_word;
            `FIR_ADDR_RESULT: rd_word = result.value;
            `FIR_ADDR_RELOAD: rd_word = {{(`FIR_DATA_W-1){1'b0}}, new_coefficient_set};
            default:          rd_word = {regs[hi_addr], regs[lo_addr]};
        endcase
        hrdata = '0;
        if (rd_ok) begin
            if (req_q.size == HSIZE_HALF) begin
                hrdata = rd_word;
            end else if (req_q.addr[0]) begin
                hrdata[15:8] = rd_word[15:8];
            end else begin
                hrdata[7:0] = rd_word[7:0];
            end
        end
    end

    // a start request is only withdrawn once the datapath took it and still runs
    assert property (@(posedge clk) disable iff (!n_rst)
        $fell(data_ready) |-> $past(modwait) && modwait);

    // errored access is selected and leaves the table untouched
    assert property (@(posedge clk) disable iff (!n_rst)
        hresp |-> hsel ##2 $stable(regs));

endmodule

// ==== verilog/coeff_loader.sv ====
`timescale 1ns/100ps
`include "fir_defines.svh"

module coeff_loader (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     new_coefficient_set,
    input  logic                     modwait,
    input  logic [`FIR_DATA_W-1:0]   fir_coefficient,
    output logic [1:0]               coefficient_num,
    output logic                     coeff_done,
    output fir_pkg::coeff_bank_t     coeff_bank
);
    import fir_pkg::*;

    load_state_e state;
    logic last_tap;

    assign last_tap = coefficient_num == 2'(`FIR_TAPS - 1);
    // pulse in the cycle the final tap is latched
    assign coeff_done = (state == LD_RUN) && last_tap;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state           <= LD_IDLE;
            coefficient_num <= '0;
            coeff_bank      <= '0;
        end else begin
            case (state)
                LD_IDLE: begin
                    // hold off while a filter pass reads the bank
                    if (new_coefficient_set && !modwait) begin
                        state           <= LD_RUN;
                        coefficient_num <= '0;
                    end
                end
                LD_RUN: begin
                    // one tap per cycle supplied combinationally by the slave
                    coeff_bank[coefficient_num] <= fir_coefficient;
                    coefficient_num <= coefficient_num + 2'd1;
                    if (last_tap) begin
                        state <= LD_IDLE;
                    end
                end
                default: begin
                    state <= LD_IDLE;
                end
            endcase
        end
    end

    // bank holds still during a filter pass
    assert property (@(posedge clk) disable iff (!n_rst)
        modwait |=> $stable(coeff_bank));

endmodule

// ==== verilog/fir_datapath.sv ====
`timescale 1ns/100ps
`include "fir_defines.svh"

module fir_datapath (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     data_ready,
    input  logic [`FIR_DATA_W-1:0]   sample_data,
    input  fir_pkg::coeff_bank_t     coeff_bank,
    output logic                     modwait,
    output fir_pkg::fir_result_t     result
);
    import fir_pkg::*;

    fir_state_e state;
    logic [1:0] tap_idx;
    // tap 0 newest
    logic [`FIR_TAPS-1:0][`FIR_DATA_W-1:0] taps;
    logic [`FIR_DATA_W-1:0] sample_hold;
    logic [2*`FIR_DATA_W-1:0] product;
    logic [`FIR_ACC_W-1:0] acc;
    logic [`FIR_ACC_W-1:0] acc_next;

    assign modwait = state != FIR_IDLE;

    // bank only read in FIR_MAC
    assign product  = coeff_bank[tap_idx] * taps[tap_idx];
    assign acc_next = acc + {{(`FIR_ACC_W - 2*`FIR_DATA_W){1'b0}}, product};

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state   <= FIR_IDLE;
            tap_idx <= '0;
            taps    <= '0;
            result  <= '0;
        end else begin
            case (state)
                FIR_IDLE: begin
                    if (data_ready) begin
                        state <= FIR_SHIFT;
                    end
                end
                FIR_SHIFT: begin
                    taps    <= {taps[`FIR_TAPS-2:0], sample_hold};
                    tap_idx <= '0;
                    state   <= FIR_MAC;
                end
                FIR_MAC: begin
                    tap_idx <= tap_idx + 2'd1;
                    if (tap_idx == 2'(`FIR_TAPS - 1)) begin
                        state        <= FIR_IDLE;
                        // upper half of the 32-bit sum, overflow above it
                        result.value <= acc_next[2*`FIR_DATA_W-1:`FIR_DATA_W];
                        result.err   <= |acc_next[`FIR_ACC_W-1:2*`FIR_DATA_W];
                    end
                end
                default: begin
                    state <= FIR_IDLE;
                end
            endcase
        end
    end

    // sample captured at start so a later bus write cannot replace it
    always_ff @(posedge clk) begin
        if ((state == FIR_IDLE) && data_ready) begin
            sample_hold <= sample_data;
        end
        if (state == FIR_SHIFT) begin
            acc <= '0;
        end else if (state == FIR_MAC) begin
            acc <= acc_next;
        end
    end

    // one shift plus four MACs per start
    assert property (@(posedge clk) disable iff (!n_rst)
        $rose(modwait) |-> modwait [*5] ##1 !modwait);

endmodule

// ==== verilog/ahb_fir_top.sv ====
`timescale 1ns/100ps
`include "fir_defines.svh"

module ahb_fir_top (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     hsel,
    input  logic [`FIR_ADDR_W-1:0]   haddr,
    input  fir_pkg::hsize_e          hsize,
    input  logic [1:0]               htrans,
    input  logic                     hwrite,
    input  logic [`FIR_DATA_W-1:0]   hwdata,
    output logic [`FIR_DATA_W-1:0]   hrdata,
    output logic                     hresp
);
    import fir_pkg::*;

    // slave and loader
    logic [1:0] coefficient_num;
    logic [`FIR_DATA_W-1:0] fir_coefficient;
    logic new_coefficient_set;
    logic coeff_done;
    // loader to datapath
    coeff_bank_t coeff_bank;
    // slave and datapath
    logic [`FIR_DATA_W-1:0] sample_data;
    logic data_ready;
    logic modwait;
    fir_result_t result;

    ahb_lite_slave i_slave (
        .clk                 (clk),
        .n_rst               (n_rst),
        .hsel                (hsel),
        .haddr               (haddr),
        .hsize               (hsize),
        .htrans              (htrans),
        .hwrite              (hwrite),
        .hwdata              (hwdata),
        .hrdata              (hrdata),
        .hresp               (hresp),
        .sample_data         (sample_data),
        .data_ready          (data_ready),
        .new_coefficient_set (new_coefficient_set),
        .fir_coefficient     (fir_coefficient),
        .coefficient_num     (coefficient_num),
        .coeff_done          (coeff_done),
        .modwait             (modwait),
        .result              (result)
    );

    coeff_loader i_loader (
        .clk                 (clk),
        .n_rst               (n_rst),
        .new_coefficient_set (new_coefficient_set),
        .modwait             (modwait),
        .fir_coefficient     (fir_coefficient),
        .coefficient_num     (coefficient_num),
        .coeff_done          (coeff_done),
        .coeff_bank          (coeff_bank)
    );

    fir_datapath i_datapath (
        .clk         (clk),
        .n_rst       (n_rst),
        .data_ready  (data_ready),
        .sample_data (sample_data),
        .coeff_bank  (coeff_bank),
        .modwait     (modwait),
        .result      (result)
    );

endmodule

// ==== dv/tb_ahb_fir.sv ====
`timescale 1ns/100ps
`include "fir_defines.svh"

module tb_ahb_fir;
    import fir_pkg::*;

    localparam int CLK_HALF = 20;
    // status reads before giving up on busy
    localparam int POLL_LIMIT = 64;
    localparam int NUM_SAMPLES = 8;

    logic clk = 1'b0;
    logic n_rst;
    logic hsel;
    logic [`FIR_ADDR_W-1:0] haddr;
    hsize_e hsize;
    logic [1:0] htrans;
    logic hwrite;
    logic [`FIR_DATA_W-1:0] hwdata;
    logic [`FIR_DATA_W-1:0] hrdata;
    logic hresp;

    // model state with tap 0 newest
    logic [`FIR_DATA_W-1:0] ref_coef [`FIR_TAPS];
    logic [`FIR_DATA_W-1:0] ref_taps [`FIR_TAPS];

    ahb_fir_top i_dut (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .hsize  (hsize),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp)
    );

    always #(CLK_HALF) clk = ~clk;

    // shifts in one sample and sums coef k times tap k
    function automatic fir_result_t fir_ref(input logic [`FIR_DATA_W-1:0] sample);
        logic [`FIR_ACC_W-1:0] acc;
        logic [2*`FIR_DATA_W-1:0] prod;
        fir_result_t res;
        int k;
        for (k = `FIR_TAPS - 1; k > 0; k--) begin
            ref_taps[k] = ref_taps[k-1];
        end
        ref_taps[0] = sample;
        acc = '0;
        for (k = 0; k < `FIR_TAPS; k++) begin
            prod = 32'(ref_coef[k]) * 32'(ref_taps[k]);
            acc = acc + {2'b00, prod};
        end
        // upper half of the 32-bit sum with overflow above it
        res.value = acc[2*`FIR_DATA_W-1:`FIR_DATA_W];
        res.err   = |acc[`FIR_ACC_W-1:2*`FIR_DATA_W];
        return res;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_rdata(input logic [`FIR_DATA_W-1:0] got,
                               input logic [`FIR_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s read 0x%04h, expected 0x%04h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_hresp(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: hresp %0b, expected %0b", $time, got, exp));
        end
    endtask

    task automatic check_result(input fir_result_t got, input fir_result_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: result 0x%04h err %0b, expected 0x%04h err %0b",
                                $time, got.value, got.err, exp.value, exp.err));
        end
    endtask

    // address phase with hresp checked mid low phase and then data phase
    task automatic ahb_write(input logic [`FIR_ADDR_W-1:0] addr, input hsize_e size,
                             input logic [`FIR_DATA_W-1:0] data, input logic exp_resp);
        @(negedge clk);
        hsel   = 1'b1;
        haddr  = addr;
        hsize  = size;
        htrans = 2'b10;
        hwrite = 1'b1;
        #(CLK_HALF / 2);
        check_hresp(hresp, exp_resp);
        @(negedge clk);
        hsel   = 1'b0;
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = data;
        // register written on this edge
        @(posedge clk);
    endtask

    task automatic ahb_read(input logic [`FIR_ADDR_W-1:0] addr, input hsize_e size,
                            input logic exp_resp, output logic [`FIR_DATA_W-1:0] data);
        @(negedge clk);
        hsel   = 1'b1;
        haddr  = addr;
        hsize  = size;
        htrans = 2'b10;
        hwrite = 1'b0;
        #(CLK_HALF / 2);
        check_hresp(hresp, exp_resp);
        @(negedge clk);
        // hrdata settled since the last rising edge
        data   = hrdata;
        hsel   = 1'b0;
        htrans = 2'b00;
    endtask

    // result register plus err from status
    task automatic read_result(output fir_result_t res);
        logic [`FIR_DATA_W-1:0] value;
        logic [`FIR_DATA_W-1:0] status;
        ahb_read(`FIR_ADDR_RESULT, HSIZE_HALF, 1'b0, value);
        ahb_read(`FIR_ADDR_STATUS, HSIZE_HALF, 1'b0, status);
        res.value = value;
        res.err   = status[`FIR_STATUS_ERR_BIT];
    endtask

    task automatic wait_idle();
        logic [`FIR_DATA_W-1:0] status;
        int polls;
        polls  = 0;
        status = 16'h0001;
        while (status[`FIR_STATUS_BUSY_BIT]) begin
            if (polls == POLL_LIMIT) begin
                abort_run("busy never cleared");
            end
            ahb_read(`FIR_ADDR_STATUS, HSIZE_HALF, 1'b0, status);
            polls++;
        end
    endtask

    // all four taps and then a reload through byte 14
    task automatic load_coeffs(input logic use_max);
        logic [`FIR_DATA_W-1:0] c;
        int k;
        for (k = 0; k < `FIR_TAPS; k++) begin
            c = use_max ? 16'hffff : 16'($urandom());
            ahb_write(`FIR_ADDR_COEF0 + 4'(2 * k), HSIZE_HALF, c, 1'b0);
            ref_coef[k] = c;
        end
        ahb_write(`FIR_ADDR_RELOAD, HSIZE_BYTE, 16'h0001, 1'b0);
        wait_idle();
    endtask

    task automatic run_sample(input logic [`FIR_DATA_W-1:0] s, output fir_result_t exp);
        fir_result_t got;
        ahb_write(`FIR_ADDR_SAMPLE, HSIZE_HALF, s, 1'b0);
        exp = fir_ref(s);
        wait_idle();
        read_result(got);
        check_result(got, exp);
    endtask

    initial begin
        fir_result_t exp;
        fir_result_t got;
        logic [`FIR_DATA_W-1:0] rd;
        logic [`FIR_DATA_W-1:0] v;
        logic [`FIR_DATA_W-1:0] w;
        logic [`FIR_DATA_W-1:0] status_before;
        logic [`FIR_ADDR_W-1:0] addr;
        int k;
        void'($urandom(32'hac5d));
        n_rst  = 1'b0;
        hsel   = 1'b0;
        haddr  = '0;
        hsize  = HSIZE_BYTE;
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = '0;
        for (k = 0; k < `FIR_TAPS; k++) begin
            ref_coef[k] = '0;
            ref_taps[k] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        // registers clear out of reset
        ahb_read(`FIR_ADDR_STATUS, HSIZE_HALF, 1'b0, rd);
        check_rdata(rd, 16'h0000, "status after reset");
        ahb_read(`FIR_ADDR_RESULT, HSIZE_HALF, 1'b0, rd);
        check_rdata(rd, 16'h0000, "result after reset");

        // lane mapping on the coefficient table
        for (k = 0; k < `FIR_TAPS; k++) begin
            addr = `FIR_ADDR_COEF0 + 4'(2 * k);
            v = 16'($urandom());
            ahb_write(addr, HSIZE_HALF, v, 1'b0);
            ahb_read(addr, HSIZE_HALF, 1'b0, rd);
            check_rdata(rd, v, "coefficient halfword");
            ahb_read(addr, HSIZE_BYTE, 1'b0, rd);
            check_rdata(rd, {8'h00, v[7:0]}, "coefficient low byte");
            ahb_read(addr + 4'd1, HSIZE_BYTE, 1'b0, rd);
            check_rdata(rd, {v[15:8], 8'h00}, "coefficient high byte");
            // other lane carries junk that must be ignored
            w = 16'($urandom());
            ahb_write(addr, HSIZE_BYTE, {~w[15:8], w[7:0]}, 1'b0);
            ahb_write(addr + 4'd1, HSIZE_BYTE, {w[15:8], ~w[7:0]}, 1'b0);
            ahb_read(addr, HSIZE_HALF, 1'b0, rd);
            check_rdata(rd, w, "coefficient after byte writes");
        end

        // random taps and samples
        load_coeffs(1'b0);
        for (k = 0; k < NUM_SAMPLES; k++) begin
            run_sample(16'($urandom()), exp);
        end

        // full scale operands overflow the 32-bit sum
        load_coeffs(1'b1);
        for (k = 0; k < `FIR_TAPS; k++) begin
            run_sample(16'hffff, exp);
        end
        ahb_read(`FIR_ADDR_STATUS, HSIZE_HALF, 1'b0, rd);
        check_rdata(rd & 16'h0100, 16'h0100, "status err bit");

        // illegal accesses error out and change nothing
        status_before = '0;
        status_before[`FIR_STATUS_ERR_BIT] = exp.err;
        for (k = 0; k < 4; k++) begin
            ahb_write(4'(k), HSIZE_BYTE, 16'hffff, 1'b1);
        end
        ahb_write(`FIR_ADDR_STATUS, HSIZE_HALF, 16'hffff, 1'b1);
        ahb_write(`FIR_ADDR_RESULT, HSIZE_HALF, 16'h0000, 1'b1);
        ahb_write(`FIR_ADDR_RELOAD + 4'd1, HSIZE_BYTE, 16'hffff, 1'b1);
        ahb_read(`FIR_ADDR_RELOAD + 4'd1, HSIZE_BYTE, 1'b1, rd);
        ahb_read(`FIR_ADDR_STATUS, HSIZE_HALF, 1'b0, rd);
        check_rdata(rd, status_before, "status after errored accesses");
        read_result(got);
        check_result(got, exp);

        // second sample lands while the first pass runs
        load_coeffs(1'b0);
        v = 16'($urandom());
        w = 16'($urandom());
        ahb_write(`FIR_ADDR_SAMPLE, HSIZE_HALF, v, 1'b0);
        ahb_write(`FIR_ADDR_SAMPLE, HSIZE_HALF, w, 1'b0);
        exp = fir_ref(v);
        exp = fir_ref(w);
        wait_idle();
        read_result(got);
        check_result(got, exp);

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/fir_pkg.sv
verilog/ahb_lite_slave.sv
verilog/coeff_loader.sv
verilog/fir_datapath.sv
verilog/ahb_fir_top.sv
dv/tb_ahb_fir.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the AHB FIR testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_ahb_fir \
    -Mdir "$BUILD_DIR" -o tb_ahb_fir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/tb_ahb_fir" > "$SIM_LOG" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see $SIM_LOG"
    exit 1
fi

# the log decides pass or fail
if grep -q "Finished with no errors" "$SIM_LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $SIM_LOG"
exit 1
